/* source/controlConsts.svh */
`ifndef CONTROL_CONSTS_SVH
`define CONTROL_CONSTS_SVH

// wait lengths in cycles.
`define MEM_WAIT_CYCLES 2'd1
`define COMPARE_WAIT_CYCLES 2'd2

`define IORD_W 2
`define ALUSRCB_W 2
`define PCSRC_W 2
`define REGDST_W 2
`define MEMTOREG_W 3

// memory address select.
`define IORD_PC 2'd0
`define IORD_ALUOUT 2'd1
`define IORD_VEC_OPCODE 2'd2
`define IORD_VEC_OVERFLOW 2'd3

`define ALUSRCA_PC 1'b0
`define ALUSRCA_REGA 1'b1

`define ALUSRCB_REGB 2'd0
`define ALUSRCB_FOUR 2'd1
`define ALUSRCB_IMM 2'd2

`define PCSRC_JUMP 2'd0
`define PCSRC_ALU 2'd1
`define PCSRC_BRANCH 2'd2

`define REGDST_RT 2'd0
`define REGDST_RD 2'd1
`define REGDST_RA 2'd2

// register write data select.
`define MEMTOREG_ALUOUT 3'd0
`define MEMTOREG_MDR 3'd1
`define MEMTOREG_PC 3'd2
`define MEMTOREG_ONE 3'd3
`define MEMTOREG_ZERO 3'd4

`endif

/* source/controlPkg.sv */
package controlPkg;

	typedef enum logic [5:0] {
		opRtype = 6'h00,
		opJ = 6'h02,
		opJal = 6'h03,
		opBeq = 6'h04,
		opBne = 6'h05,
		opBle = 6'h06,
		opBgt = 6'h07,
		opAddi = 6'h08,
		opAddiu = 6'h09,
		opSlti = 6'h0a,
		opLw = 6'h23,
		opSw = 6'h2b
	} opcode_t;

	// funct field, meaningful under opRtype only.
	typedef enum logic [5:0] {
		fnJr = 6'h08,
		fnBreak = 6'h0d,
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnSlt = 6'h2a
	} funct_t;

	typedef enum logic [4:0] {
		kindAdd, kindSub, kindAnd, kindSlt,
		kindAddi, kindAddiu, kindSlti,
		kindBeq, kindBne, kindBle, kindBgt,
		kindJ, kindJal, kindJr,
		kindLw, kindSw,
		kindBreak, kindInvalid
	} instrKind_t;

	typedef enum logic [2:0] {
		aluAdd = 3'b001,
		aluSub = 3'b010,
		aluAnd = 3'b011,
		aluCompare = 3'b111 // sets the compare flags.
	} aluOp_t;

	typedef enum logic [4:0] {
		fetchAddr, fetchWait, pcUpdate, irLoad, operandLoad, decode,
		aluExec, aluWrite, compareWait, setWrite, branchTake,
		jump, jalLink, jalJump, jumpReg,
		memAddr, memRead, memWait, mdrLoad, loadWrite, storeWrite,
		trapEntry, trapWait, trapLoad, trapJump,
		halt
	} ctrlState_t;

endpackage

/* source/opcodeDecoder.sv */
`timescale 1ns/100ps

module opcodeDecoder (
	input controlPkg::opcode_t opcode,
	input controlPkg::funct_t funct,
	output controlPkg::instrKind_t instrKind
);

	always_comb begin
		case (opcode)
			controlPkg::opRtype: begin
				case (funct)
					controlPkg::fnAdd: instrKind = controlPkg::kindAdd;
					controlPkg::fnSub: instrKind = controlPkg::kindSub;
					controlPkg::fnAnd: instrKind = controlPkg::kindAnd;
					controlPkg::fnSlt: instrKind = controlPkg::kindSlt;
					controlPkg::fnJr: instrKind = controlPkg::kindJr;
					controlPkg::fnBreak: instrKind = controlPkg::kindBreak;
					default: instrKind = controlPkg::kindInvalid; // unknown funct traps too.
				endcase
			end
			controlPkg::opAddi: instrKind = controlPkg::kindAddi;
			controlPkg::opAddiu: instrKind = controlPkg::kindAddiu;
			controlPkg::opSlti: instrKind = controlPkg::kindSlti;
			controlPkg::opBeq: instrKind = controlPkg::kindBeq;
			controlPkg::opBne: instrKind = controlPkg::kindBne;
			controlPkg::opBle: instrKind = controlPkg::kindBle;
			controlPkg::opBgt: instrKind = controlPkg::kindBgt;
			controlPkg::opJ: instrKind = controlPkg::kindJ;
			controlPkg::opJal: instrKind = controlPkg::kindJal;
			controlPkg::opLw: instrKind = controlPkg::kindLw;
			controlPkg::opSw: instrKind = controlPkg::kindSw;
			default: instrKind = controlPkg::kindInvalid;
		endcase
	end

endmodule

/* source/controlSequencer.sv */
`timescale 1ns/100ps

`include "controlConsts.svh"

module controlSequencer (
	input logic clock,
	input logic reset,
	input controlPkg::instrKind_t instrKind,
	input logic zero,
	input logic overflow,
	input logic greater,
	input logic less,
	output controlPkg::ctrlState_t state,
	output controlPkg::instrKind_t currentKind
);

	controlPkg::ctrlState_t nextState;
	logic [1:0] waitCount;
	logic [1:0] waitLength;
	logic inWait;
	logic waitDone;
	logic branchTaken;
	logic trapsOnOverflow;

	assign inWait = state inside {controlPkg::memWait, controlPkg::trapWait,
		controlPkg::compareWait};
	assign waitLength = (state == controlPkg::compareWait) ? `COMPARE_WAIT_CYCLES
		: `MEM_WAIT_CYCLES;
	assign waitDone = waitCount == (waitLength - 2'd1);

	// only add, sub and addi trap on overflow.
	assign trapsOnOverflow = currentKind inside {controlPkg::kindAdd, controlPkg::kindSub,
		controlPkg::kindAddi};

	always_comb begin
		case (currentKind)
			controlPkg::kindBeq: branchTaken = zero;
			controlPkg::kindBne: branchTaken = !zero;
			controlPkg::kindBle: branchTaken = !greater;
			controlPkg::kindBgt: branchTaken = greater;
			default: branchTaken = 1'b0;
		endcase
	end

	always_comb begin
		nextState = state;
		case (state)
			controlPkg::fetchAddr: nextState = controlPkg::fetchWait;
			controlPkg::fetchWait: nextState = controlPkg::pcUpdate;
			controlPkg::pcUpdate: nextState = controlPkg::irLoad;
			controlPkg::irLoad: nextState = controlPkg::operandLoad;
			controlPkg::operandLoad: nextState = controlPkg::decode;
			controlPkg::decode: begin
				case (instrKind)
					controlPkg::kindJ: nextState = controlPkg::jump;
					controlPkg::kindJal: nextState = controlPkg::jalLink;
					controlPkg::kindJr: nextState = controlPkg::jumpReg;
					controlPkg::kindLw,
					controlPkg::kindSw: nextState = controlPkg::memAddr;
					controlPkg::kindBreak: nextState = controlPkg::halt;
					controlPkg::kindInvalid: nextState = controlPkg::trapEntry;
					default: nextState = controlPkg::aluExec; // alu, set-less and branches.
				endcase
			end
			controlPkg::aluExec: begin
				if (trapsOnOverflow && overflow)
					nextState = controlPkg::trapEntry;
				else if (currentKind inside {controlPkg::kindAdd, controlPkg::kindSub,
					controlPkg::kindAnd, controlPkg::kindAddi, controlPkg::kindAddiu})
					nextState = controlPkg::aluWrite;
				else
					nextState = controlPkg::compareWait;
			end
			controlPkg::compareWait: begin
				if (waitDone) begin
					if (currentKind inside {controlPkg::kindSlt, controlPkg::kindSlti})
						nextState = controlPkg::setWrite;
					else if (branchTaken)
						nextState = controlPkg::branchTake;
					else
						nextState = controlPkg::fetchAddr;
				end
			end
			controlPkg::jalLink: nextState = controlPkg::jalJump;
			controlPkg::memAddr: begin
				nextState = (currentKind == controlPkg::kindLw) ? controlPkg::memRead
					: controlPkg::storeWrite;
			end
			controlPkg::memRead: nextState = controlPkg::memWait;
			controlPkg::memWait: if (waitDone) nextState = controlPkg::mdrLoad;
			controlPkg::mdrLoad: nextState = controlPkg::loadWrite;
			controlPkg::trapEntry: nextState = controlPkg::trapWait;
			controlPkg::trapWait: if (waitDone) nextState = controlPkg::trapLoad;
			controlPkg::trapLoad: nextState = controlPkg::trapJump;
			controlPkg::halt: nextState = controlPkg::halt;
			default: nextState = controlPkg::fetchAddr; // single-cycle closing states.
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= controlPkg::fetchAddr;
			currentKind <= controlPkg::kindInvalid;
			waitCount <= 2'd0;
		end else begin
			state <= nextState;
			if (state == controlPkg::decode)
				currentKind <= instrKind; // opcode is only valid around decode.
			if (inWait && !waitDone)
				waitCount <= waitCount + 2'd1;
			else
				waitCount <= 2'd0;
		end
	end

	waitBound: assert property (@(posedge clock) disable iff (reset)
		waitCount < ((`MEM_WAIT_CYCLES > `COMPARE_WAIT_CYCLES) ? `MEM_WAIT_CYCLES
		: `COMPARE_WAIT_CYCLES));

	haltSticky: assert property (@(posedge clock) disable iff (reset)
		state == controlPkg::halt |=> state == controlPkg::halt);

	noRefetch: assert property (@(posedge clock) disable iff (reset)
		state == controlPkg::decode |=> !(state inside {controlPkg::fetchAddr,
		controlPkg::fetchWait, controlPkg::pcUpdate, controlPkg::irLoad,
		controlPkg::operandLoad, controlPkg::decode}));

	// datapath compare flags are exclusive once settled.
	flagsSettled: assert property (@(posedge clock) disable iff (reset)
		state == controlPkg::compareWait && waitDone |-> !(greater && less));

endmodule

/* source/strobeDecoder.sv */
`timescale 1ns/100ps

`include "controlConsts.svh"

module strobeDecoder (
	input controlPkg::ctrlState_t state,
	input controlPkg::instrKind_t currentKind,
	input logic less,
	output logic [`IORD_W-1:0] iorD,
	output logic aluSrcA,
	output logic [`ALUSRCB_W-1:0] aluSrcB,
	output controlPkg::aluOp_t aluOp,
	output logic [`PCSRC_W-1:0] pcSource,
	output logic aluOrMem,
	output logic [`REGDST_W-1:0] regDst,
	output logic [`MEMTOREG_W-1:0] memToReg,
	output logic signExtend,
	output logic memWrite,
	output logic irWrite,
	output logic pcWrite,
	output logic regWrite,
	output logic aWrite,
	output logic bWrite,
	output logic aluOutWrite,
	output logic mdrWrite,
	output logic epcWrite
);

	logic isRtype;
	logic isImmediate;
	controlPkg::aluOp_t execOp;
	logic [`IORD_W-1:0] trapVector;

	always_comb begin
		isRtype = currentKind inside {controlPkg::kindAdd, controlPkg::kindSub,
			controlPkg::kindAnd, controlPkg::kindSlt};
		isImmediate = currentKind inside {controlPkg::kindAddi, controlPkg::kindAddiu,
			controlPkg::kindSlti};
		case (currentKind)
			controlPkg::kindSub, controlPkg::kindBeq, controlPkg::kindBne: execOp = controlPkg::aluSub;
			controlPkg::kindAnd: execOp = controlPkg::aluAnd;
			controlPkg::kindSlt, controlPkg::kindSlti,
			controlPkg::kindBle, controlPkg::kindBgt: execOp = controlPkg::aluCompare;
			default: execOp = controlPkg::aluAdd;
		endcase
		trapVector = (currentKind == controlPkg::kindInvalid) ? `IORD_VEC_OPCODE
			: `IORD_VEC_OVERFLOW;
	end

	always_comb begin
		iorD = `IORD_PC;
		aluSrcA = `ALUSRCA_PC;
		aluSrcB = `ALUSRCB_FOUR;
		aluOp = controlPkg::aluAdd;
		pcSource = `PCSRC_ALU;
		aluOrMem = 1'b0;
		regDst = `REGDST_RT;
		memToReg = `MEMTOREG_ALUOUT;
		signExtend = 1'b0;
		memWrite = 1'b0;
		irWrite = 1'b0;
		pcWrite = 1'b0;
		regWrite = 1'b0;
		aWrite = 1'b0;
		bWrite = 1'b0;
		aluOutWrite = 1'b0;
		mdrWrite = 1'b0;
		epcWrite = 1'b0;
		case (state)
			controlPkg::pcUpdate: pcWrite = 1'b1; // pc + 4.
			controlPkg::irLoad: begin
				irWrite = 1'b1;
				mdrWrite = 1'b1;
			end
			controlPkg::operandLoad: begin
				aWrite = 1'b1;
				bWrite = 1'b1;
				// branch target into aluOut ahead of decode.
				aluSrcB = `ALUSRCB_IMM;
				signExtend = 1'b1;
				aluOutWrite = 1'b1;
			end
			controlPkg::aluExec, controlPkg::compareWait: begin
				aluSrcA = `ALUSRCA_REGA;
				aluSrcB = isImmediate ? `ALUSRCB_IMM : `ALUSRCB_REGB;
				signExtend = isImmediate;
				aluOp = execOp;
				// branches keep the target held in aluOut.
				aluOutWrite = (state == controlPkg::aluExec) && !(currentKind inside
					{controlPkg::kindBeq, controlPkg::kindBne, controlPkg::kindBle,
					controlPkg::kindBgt});
			end
			controlPkg::aluWrite: begin
				regWrite = 1'b1;
				regDst = isRtype ? `REGDST_RD : `REGDST_RT;
			end
			controlPkg::setWrite: begin
				regWrite = 1'b1;
				regDst = isRtype ? `REGDST_RD : `REGDST_RT;
				memToReg = less ? `MEMTOREG_ONE : `MEMTOREG_ZERO;
			end
			controlPkg::branchTake: begin
				pcSource = `PCSRC_BRANCH;
				pcWrite = 1'b1;
			end
			controlPkg::jump, controlPkg::jalJump: begin
				pcSource = `PCSRC_JUMP;
				pcWrite = 1'b1;
			end
			controlPkg::jalLink: begin
				regWrite = 1'b1;
				regDst = `REGDST_RA;
				memToReg = `MEMTOREG_PC;
			end
			controlPkg::jumpReg: begin
				aluSrcA = `ALUSRCA_REGA;
				aluSrcB = `ALUSRCB_REGB; // rt is $zero for jr.
				pcWrite = 1'b1;
			end
			controlPkg::memAddr: begin
				aluSrcA = `ALUSRCA_REGA;
				aluSrcB = `ALUSRCB_IMM;
				signExtend = 1'b1;
				aluOutWrite = 1'b1;
			end
			controlPkg::memRead, controlPkg::memWait: iorD = `IORD_ALUOUT;
			controlPkg::mdrLoad: begin
				iorD = `IORD_ALUOUT;
				mdrWrite = 1'b1;
			end
			controlPkg::loadWrite: begin
				regWrite = 1'b1;
				memToReg = `MEMTOREG_MDR;
			end
			controlPkg::storeWrite: begin
				iorD = `IORD_ALUOUT;
				memWrite = 1'b1;
			end
			controlPkg::trapEntry: begin
				iorD = trapVector;
				aluOp = controlPkg::aluSub; // epc gets pc - 4.
				epcWrite = 1'b1;
			end
			controlPkg::trapWait: iorD = trapVector;
			controlPkg::trapLoad: begin
				iorD = trapVector;
				mdrWrite = 1'b1;
			end
			controlPkg::trapJump: begin
				aluOrMem = 1'b1; // handler address from the vector byte.
				pcWrite = 1'b1;
			end
			default: ; // fetchAddr, fetchWait, decode and halt drive nothing.
		endcase
	end

endmodule

/* source/controlUnit.sv */
`timescale 1ns/100ps

`include "controlConsts.svh"

module controlUnit (
	input logic clock,
	input logic reset,
	input controlPkg::opcode_t opcode,
	input controlPkg::funct_t funct,
	input logic zero,
	input logic overflow,
	input logic greater,
	input logic less,
	output logic [`IORD_W-1:0] iorD,
	output logic aluSrcA,
	output logic [`ALUSRCB_W-1:0] aluSrcB,
	output controlPkg::aluOp_t aluOp,
	output logic [`PCSRC_W-1:0] pcSource,
	output logic aluOrMem,
	output logic [`REGDST_W-1:0] regDst,
	output logic [`MEMTOREG_W-1:0] memToReg,
	output logic signExtend,
	output logic memWrite,
	output logic irWrite,
	output logic pcWrite,
	output logic regWrite,
	output logic aWrite,
	output logic bWrite,
	output logic aluOutWrite,
	output logic mdrWrite,
	output logic epcWrite
);

	controlPkg::instrKind_t instrKind;
	controlPkg::instrKind_t currentKind;
	controlPkg::ctrlState_t state;

	opcodeDecoder decoder (
		.opcode(opcode),
		.funct(funct),
		.instrKind(instrKind)
	);

	controlSequencer sequencer (
		.clock(clock),
		.reset(reset),
		.instrKind(instrKind),
		.zero(zero),
		.overflow(overflow),
		.greater(greater),
		.less(less),
		.state(state),
		.currentKind(currentKind)
	);

	strobeDecoder strobes (
		.state(state),
		.currentKind(currentKind),
		.less(less),
		.iorD(iorD),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.aluOp(aluOp),
		.pcSource(pcSource),
		.aluOrMem(aluOrMem),
		.regDst(regDst),
		.memToReg(memToReg),
		.signExtend(signExtend),
		.memWrite(memWrite),
		.irWrite(irWrite),
		.pcWrite(pcWrite),
		.regWrite(regWrite),
		.aWrite(aWrite),
		.bWrite(bWrite),
		.aluOutWrite(aluOutWrite),
		.mdrWrite(mdrWrite),
		.epcWrite(epcWrite)
	);

endmodule

/* bench/controlUnitTb.sv */
`timescale 1ns/100ps

`include "controlConsts.svh"

module controlUnitTb;

	typedef struct packed {
		logic [5:0] op;
		logic [5:0] fn;
		logic [3:0] flags; // zero, overflow, greater, less.
		int execCycles;
		int regWrites;
		int memWrites;
		int pcWrites;
		int epcWrites;
		int mdrWrites;
		logic [`REGDST_W-1:0] regDst;
		logic [`MEMTOREG_W-1:0] memToReg;
		logic [`IORD_W-1:0] iorD;
		logic [`PCSRC_W-1:0] pcSource;
		logic aluOrMem;
		logic aluSrcA;
		logic [`ALUSRCB_W-1:0] aluSrcB;
		logic [2:0] aluOp;
		logic signExtend;
	} testRow_t;

	localparam int NUM_ROWS = 31;
	localparam int FETCH_CYCLES = 6;
	localparam int IR_LOAD_INDEX = 3; // fetchAddr, fetchWait, pcUpdate, irLoad.
	localparam int FIRST_EXEC_CYCLE = 3; // operandLoad, decode, then execute.
	localparam int HALT_QUIET_CYCLES = 20;
	localparam int TIMEOUT_CYCLES = (NUM_ROWS + 1) * 20 + 50;

	// op, funct, flags, execute cycles, then regWrite, memWrite, pcWrite,
	// epcWrite and mdrWrite pulses from operandLoad up to the next irLoad.
	// regDst and memToReg count only with a regWrite, iorD only with an epcWrite.
	// second line: pcSource and aluOrMem at the first pcWrite, then aluSrcA,
	// aluSrcB, aluOp and signExtend in the first cycle after decode.
	testRow_t rows [NUM_ROWS] = '{
		'{6'h00, 6'h20, 4'b0000, 2, 1, 0, 1, 0, 1, `REGDST_RD, `MEMTOREG_ALUOUT, `IORD_PC, // add
			`PCSRC_ALU, 1'b0, `ALUSRCA_REGA, `ALUSRCB_REGB, controlPkg::aluAdd, 1'b0},
		'{6'h00, 6'h22, 4'b0000, 2, 1, 0, 1, 0, 1, `REGDST_RD, `MEMTOREG_ALUOUT, `IORD_PC, // sub
			`PCSRC_ALU, 1'b0, `ALUSRCA_REGA, `ALUSRCB_REGB, controlPkg::aluSub, 1'b0},
		'{6'h00, 6'h24, 4'b0000, 2, 1, 0, 1, 0, 1, `REGDST_RD, `MEMTOREG_ALUOUT, `IORD_PC, // and
			`PCSRC_ALU, 1'b0, `ALUSRCA_REGA, `ALUSRCB_REGB, controlPkg::aluAnd, 1'b0},
		'{6'h08, 6'h00, 4'b0000, 2, 1, 0, 1, 0, 1, `REGDST_RT, `MEMTOREG_ALUOUT, `IORD_PC,
			`PCSRC_ALU, 1'b0, `ALUSRCA_REGA, `ALUSRCB_IMM, controlPkg::aluAdd, 1'b1},
		'{6'h09, 6'h00, 4'b0000, 2, 1, 0, 1, 0, 1, `REGDST_RT, `MEMTOREG_ALUOUT, `IORD_PC,
			`PCSRC_ALU, 1'b0, `ALUSRCA_REGA, `ALUSRCB_IMM, controlPkg::aluAdd, 1'b1},
		'{6'h00, 6'h2a, 4'b0001, 4, 1, 0, 1, 0, 1, `REGDST_RD, `MEMTOREG_ONE, `IORD_PC, // slt
			`PCSRC_ALU, 1'b0, `ALUSRCA_REGA, `ALUSRCB_REGB, controlPkg::aluCompare, 1'b0},
		'{6'h00, 6'h2a, 4'b0010, 4, 1, 0, 1, 0, 1, `REGDST_RD, `MEMTOREG_ZERO, `IORD_PC,
			`PCSRC_ALU, 1'b0, `ALUSRCA_REGA, `ALUSRCB_REGB, controlPkg::aluCompare, 1'b0},
		'{6'h0a, 6'h00, 4'b0001, 4, 1, 0, 1, 0, 1, `REGDST_RT, `MEMTOREG_ONE, `IORD_PC, // slti
			`PCSRC_ALU, 1'b0, `ALUSRCA_REGA, `ALUSRCB_IMM, controlPkg::aluCompare, 1'b1},
		'{6'h0a, 6'h00, 4'b0000, 4, 1, 0, 1, 0, 1, `REGDST_RT, `MEMTOREG_ZERO, `IORD_PC,
			`PCSRC_ALU, 1'b0, `ALUSRCA_REGA, `ALUSRCB_IMM, controlPkg::aluCompare, 1'b1},
		'{6'h04, 6'h00, 4'b1000, 4, 0, 0, 2, 0, 1, `REGDST_RT, `MEMTOREG_PC, `IORD_PC, // beq
			`PCSRC_BRANCH, 1'b0, `ALUSRCA_REGA, `ALUSRCB_REGB, controlPkg::aluSub, 1'b0},
		'{6'h04, 6'h00, 4'b0000, 3, 0, 0, 1, 0, 1, `REGDST_RT, `MEMTOREG_PC, `IORD_PC,
			`PCSRC_ALU, 1'b0, `ALUSRCA_REGA, `ALUSRCB_REGB, controlPkg::aluSub, 1'b0},
		'{6'h05, 6'h00, 4'b0000, 4, 0, 0, 2, 0, 1, `REGDST_RT, `MEMTOREG_PC, `IORD_PC, // bne
			`PCSRC_BRANCH, 1'b0, `ALUSRCA_REGA, `ALUSRCB_REGB, controlPkg::aluSub, 1'b0},
		'{6'h05, 6'h00, 4'b1000, 3, 0, 0, 1, 0, 1, `REGDST_RT, `MEMTOREG_PC, `IORD_PC,
			`PCSRC_ALU, 1'b0, `ALUSRCA_REGA, `ALUSRCB_REGB, controlPkg::aluSub, 1'b0},
		'{6'h06, 6'h00, 4'b0001, 4, 0, 0, 2, 0, 1, `REGDST_RT, `MEMTOREG_PC, `IORD_PC, // ble
			`PCSRC_BRANCH, 1'b0, `ALUSRCA_REGA, `ALUSRCB_REGB, controlPkg::aluCompare, 1'b0},
		'{6'h06, 6'h00, 4'b1000, 4, 0, 0, 2, 0, 1, `REGDST_RT, `MEMTOREG_PC, `IORD_PC,
			`PCSRC_BRANCH, 1'b0, `ALUSRCA_REGA, `ALUSRCB_REGB, controlPkg::aluCompare, 1'b0},
		'{6'h06, 6'h00, 4'b0010, 3, 0, 0, 1, 0, 1, `REGDST_RT, `MEMTOREG_PC, `IORD_PC,
			`PCSRC_ALU, 1'b0, `ALUSRCA_REGA, `ALUSRCB_REGB, controlPkg::aluCompare, 1'b0},
		'{6'h07, 6'h00, 4'b0010, 4, 0, 0, 2, 0, 1, `REGDST_RT, `MEMTOREG_PC, `IORD_PC, // bgt
			`PCSRC_BRANCH, 1'b0, `ALUSRCA_REGA, `ALUSRCB_REGB, controlPkg::aluCompare, 1'b0},
		'{6'h07, 6'h00, 4'b0001, 3, 0, 0, 1, 0, 1, `REGDST_RT, `MEMTOREG_PC, `IORD_PC,
			`PCSRC_ALU, 1'b0, `ALUSRCA_REGA, `ALUSRCB_REGB, controlPkg::aluCompare, 1'b0},
		'{6'h02, 6'h00, 4'b0000, 1, 0, 0, 2, 0, 1, `REGDST_RT, `MEMTOREG_PC, `IORD_PC, // j
			`PCSRC_JUMP, 1'b0, `ALUSRCA_PC, `ALUSRCB_FOUR, controlPkg::aluAdd, 1'b0},
		'{6'h00, 6'h08, 4'b0000, 1, 0, 0, 2, 0, 1, `REGDST_RT, `MEMTOREG_PC, `IORD_PC, // jr
			`PCSRC_ALU, 1'b0, `ALUSRCA_REGA, `ALUSRCB_REGB, controlPkg::aluAdd, 1'b0},
		'{6'h03, 6'h00, 4'b0000, 2, 1, 0, 2, 0, 1, `REGDST_RA, `MEMTOREG_PC, `IORD_PC, // jal
			`PCSRC_JUMP, 1'b0, `ALUSRCA_PC, `ALUSRCB_FOUR, controlPkg::aluAdd, 1'b0},
		'{6'h23, 6'h00, 4'b0000, 5, 1, 0, 1, 0, 2, `REGDST_RT, `MEMTOREG_MDR, `IORD_PC, // lw
			`PCSRC_ALU, 1'b0, `ALUSRCA_REGA, `ALUSRCB_IMM, controlPkg::aluAdd, 1'b1},
		'{6'h2b, 6'h00, 4'b0000, 2, 0, 1, 1, 0, 1, `REGDST_RT, `MEMTOREG_PC, `IORD_PC, // sw
			`PCSRC_ALU, 1'b0, `ALUSRCA_REGA, `ALUSRCB_IMM, controlPkg::aluAdd, 1'b1},
		// unknown opcode, then unknown funct.
		'{6'h3f, 6'h00, 4'b0000, 4, 0, 0, 2, 1, 2, `REGDST_RT, `MEMTOREG_PC, `IORD_VEC_OPCODE,
			`PCSRC_ALU, 1'b1, `ALUSRCA_PC, `ALUSRCB_FOUR, controlPkg::aluSub, 1'b0},
		'{6'h00, 6'h3f, 4'b0000, 4, 0, 0, 2, 1, 2, `REGDST_RT, `MEMTOREG_PC, `IORD_VEC_OPCODE,
			`PCSRC_ALU, 1'b1, `ALUSRCA_PC, `ALUSRCB_FOUR, controlPkg::aluSub, 1'b0},
		// add, sub and addi trap on overflow.
		'{6'h00, 6'h20, 4'b0100, 5, 0, 0, 2, 1, 2, `REGDST_RT, `MEMTOREG_PC, `IORD_VEC_OVERFLOW,
			`PCSRC_ALU, 1'b1, `ALUSRCA_REGA, `ALUSRCB_REGB, controlPkg::aluAdd, 1'b0},
		'{6'h00, 6'h22, 4'b0100, 5, 0, 0, 2, 1, 2, `REGDST_RT, `MEMTOREG_PC, `IORD_VEC_OVERFLOW,
			`PCSRC_ALU, 1'b1, `ALUSRCA_REGA, `ALUSRCB_REGB, controlPkg::aluSub, 1'b0},
		'{6'h08, 6'h00, 4'b0100, 5, 0, 0, 2, 1, 2, `REGDST_RT, `MEMTOREG_PC, `IORD_VEC_OVERFLOW,
			`PCSRC_ALU, 1'b1, `ALUSRCA_REGA, `ALUSRCB_IMM, controlPkg::aluAdd, 1'b1},
		// overflow ignored here.
		'{6'h00, 6'h24, 4'b0100, 2, 1, 0, 1, 0, 1, `REGDST_RD, `MEMTOREG_ALUOUT, `IORD_PC,
			`PCSRC_ALU, 1'b0, `ALUSRCA_REGA, `ALUSRCB_REGB, controlPkg::aluAnd, 1'b0},
		'{6'h09, 6'h00, 4'b0100, 2, 1, 0, 1, 0, 1, `REGDST_RT, `MEMTOREG_ALUOUT, `IORD_PC,
			`PCSRC_ALU, 1'b0, `ALUSRCA_REGA, `ALUSRCB_IMM, controlPkg::aluAdd, 1'b1},
		'{6'h00, 6'h2a, 4'b0101, 4, 1, 0, 1, 0, 1, `REGDST_RD, `MEMTOREG_ONE, `IORD_PC,
			`PCSRC_ALU, 1'b0, `ALUSRCA_REGA, `ALUSRCB_REGB, controlPkg::aluCompare, 1'b0}
	};

	logic clock;
	logic reset;
	controlPkg::opcode_t opcode;
	controlPkg::funct_t funct;
	logic zero;
	logic overflow;
	logic greater;
	logic less;
	logic [`IORD_W-1:0] iorD;
	logic aluSrcA;
	logic [`ALUSRCB_W-1:0] aluSrcB;
	controlPkg::aluOp_t aluOp;
	logic [`PCSRC_W-1:0] pcSource;
	logic aluOrMem;
	logic [`REGDST_W-1:0] regDst;
	logic [`MEMTOREG_W-1:0] memToReg;
	logic signExtend;
	logic memWrite;
	logic irWrite;
	logic pcWrite;
	logic regWrite;
	logic aWrite;
	logic bWrite;
	logic aluOutWrite;
	logic mdrWrite;
	logic epcWrite;

	int errorCount = 0;
	int checkTotal = 0;
	int cycleCount = 0;

	controlUnit DUT (
		.clock(clock),
		.reset(reset),
		.opcode(opcode),
		.funct(funct),
		.zero(zero),
		.overflow(overflow),
		.greater(greater),
		.less(less),
		.iorD(iorD),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.aluOp(aluOp),
		.pcSource(pcSource),
		.aluOrMem(aluOrMem),
		.regDst(regDst),
		.memToReg(memToReg),
		.signExtend(signExtend),
		.memWrite(memWrite),
		.irWrite(irWrite),
		.pcWrite(pcWrite),
		.regWrite(regWrite),
		.aWrite(aWrite),
		.bWrite(bWrite),
		.aluOutWrite(aluOutWrite),
		.mdrWrite(mdrWrite),
		.epcWrite(epcWrite)
	);

	always #4 clock = ~clock; // 8 ns period.

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	function automatic logic anyWrite();
		return memWrite | irWrite | pcWrite | regWrite | aWrite | bWrite | aluOutWrite
			| mdrWrite | epcWrite;
	endfunction

	task automatic checkCount(input string what, input int got, input int expected);
		checkTotal++;
		assert (got == expected) else begin
			errorCount++;
			$display("ERR %0t: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	task automatic checkQuiet(input string where);
		checkTotal++;
		assert (!anyWrite()) else begin
			errorCount++;
			$display("ERR %0t: write strobe active %s", $time, where);
		end
	endtask

	initial begin
		int i;
		int cycles;
		int regCount;
		int memCount;
		int pcCount;
		int epcCount;
		int mdrCount;
		logic [`REGDST_W-1:0] seenRegDst;
		logic [`MEMTOREG_W-1:0] seenMemToReg;
		logic [`IORD_W-1:0] seenIorD;
		logic [`PCSRC_W-1:0] seenPcSource;
		logic seenAluOrMem;
		logic seenAluSrcA;
		logic [`ALUSRCB_W-1:0] seenAluSrcB;
		logic [2:0] seenAluOp;
		logic seenSignExtend;

		clock = 1'b0;
		reset = 1'b1;
		opcode = controlPkg::opRtype;
		funct = controlPkg::fnAdd;
		zero = 1'b0;
		overflow = 1'b0;
		greater = 1'b0;
		less = 1'b0;

		for (i = 0; i < 4; i++) begin
			@(posedge clock);
			if (i == 3)
				reset <= 1'b0;
			@(negedge clock);
			checkQuiet("during reset or the first cycle after it");
		end

		// first fetch, fetchAddr already seen.
		cycles = 0;
		pcCount = 0;
		do begin
			@(negedge clock);
			cycles++;
			if (pcWrite)
				pcCount++;
		end while (!irWrite);
		checkCount("first fetch cycles to irWrite", cycles, IR_LOAD_INDEX);
		checkCount("first fetch pcWrite pulses", pcCount, 1);

		for (i = 0; i < NUM_ROWS; i++) begin
			@(posedge clock); // instruction register loads here.
			opcode <= controlPkg::opcode_t'(rows[i].op);
			funct <= controlPkg::funct_t'(rows[i].fn);
			{zero, overflow, greater, less} <= rows[i].flags;
			cycles = 0;
			regCount = 0;
			memCount = 0;
			pcCount = 0;
			epcCount = 0;
			mdrCount = 0;
			seenRegDst = '0;
			seenMemToReg = '0;
			seenIorD = '0;
			seenPcSource = '0;
			seenAluOrMem = 1'b0;
			seenAluSrcA = 1'b0;
			seenAluSrcB = '0;
			seenAluOp = '0;
			seenSignExtend = 1'b0;
			do begin
				@(negedge clock);
				cycles++;
				if (cycles == FIRST_EXEC_CYCLE) begin
					seenAluSrcA = aluSrcA;
					seenAluSrcB = aluSrcB;
					seenAluOp = aluOp;
					seenSignExtend = signExtend;
				end
				if (regWrite) begin
					regCount++;
					seenRegDst = regDst;
					seenMemToReg = memToReg;
				end
				if (epcWrite) begin
					epcCount++;
					seenIorD = iorD;
				end
				if (memWrite)
					memCount++;
				if (pcWrite) begin
					if (pcCount == 0) begin
						seenPcSource = pcSource;
						seenAluOrMem = aluOrMem;
					end
					pcCount++;
				end
				if (mdrWrite)
					mdrCount++;
			end while (!irWrite);
			checkCount($sformatf("row %0d execute cycles", i), cycles - FETCH_CYCLES,
				rows[i].execCycles);
			checkCount($sformatf("row %0d regWrite pulses", i), regCount, rows[i].regWrites);
			checkCount($sformatf("row %0d memWrite pulses", i), memCount, rows[i].memWrites);
			checkCount($sformatf("row %0d pcWrite pulses", i), pcCount, rows[i].pcWrites);
			checkCount($sformatf("row %0d epcWrite pulses", i), epcCount, rows[i].epcWrites);
			checkCount($sformatf("row %0d mdrWrite pulses", i), mdrCount, rows[i].mdrWrites);
			checkCount($sformatf("row %0d pcSource", i), int'(seenPcSource),
				int'(rows[i].pcSource));
			checkCount($sformatf("row %0d aluOrMem", i), int'(seenAluOrMem),
				int'(rows[i].aluOrMem));
			checkCount($sformatf("row %0d aluSrcA", i), int'(seenAluSrcA),
				int'(rows[i].aluSrcA));
			checkCount($sformatf("row %0d aluSrcB", i), int'(seenAluSrcB),
				int'(rows[i].aluSrcB));
			checkCount($sformatf("row %0d aluOp", i), int'(seenAluOp), int'(rows[i].aluOp));
			checkCount($sformatf("row %0d signExtend", i), int'(seenSignExtend),
				int'(rows[i].signExtend));
			if (rows[i].regWrites > 0) begin
				checkCount($sformatf("row %0d regDst", i), int'(seenRegDst),
					int'(rows[i].regDst));
				checkCount($sformatf("row %0d memToReg", i), int'(seenMemToReg),
					int'(rows[i].memToReg));
			end
			if (rows[i].epcWrites > 0)
				checkCount($sformatf("row %0d iorD", i), int'(seenIorD), int'(rows[i].iorD));
		end

		// break, then the unit should sit in halt.
		@(posedge clock);
		opcode <= controlPkg::opRtype;
		funct <= controlPkg::fnBreak;
		{zero, overflow, greater, less} <= 4'b0000;
		repeat (2) @(negedge clock); // operandLoad and decode.
		for (i = 0; i < HALT_QUIET_CYCLES; i++) begin
			@(negedge clock);
			checkQuiet("after break");
		end

		$display("Checks run: %0d, errors: %0d", checkTotal, errorCount);
		if (errorCount == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* src.f */
+incdir+source
source/controlPkg.sv
source/opcodeDecoder.sv
source/controlSequencer.sv
source/strobeDecoder.sv
source/controlUnit.sv
bench/controlUnitTb.sv

/* run.sh */
#!/bin/sh
# Build and run the control unit testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module controlUnitTb -o controlUnitSim

output=$(./obj_dir/controlUnitSim || true)
echo "$output"

if echo "$output" | grep -qx "ALL TESTS PASSED"; then
	exit 0
fi
exit 1
